/* design/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Data path widths
`define WORD_W 32
`define LINE_W 512

// Address split, tag + index + offset
`define ADDR_W 32
`define TAG_W 18
`define INDEX_W 8
`define OFFSET_W 6

// Direct mapped, one line per index
`define NUM_LINES 256

`endif

/* design/cache_pkg.sv */
`include "cache_settings.svh"

package cache_pkg;

    // Address fields as the controller and store see them
    typedef struct packed {
        logic [`TAG_W-1:0]    tag;
        logic [`INDEX_W-1:0]  index;
        logic [`OFFSET_W-1:0] offset;
    } addr_fields_t;

    typedef union packed {
        logic [`ADDR_W-1:0] word;  // Raw processor address
        addr_fields_t       f;     // Split view
    } cache_addr_t;

    // Memory line port operation level
    typedef enum logic [1:0] {
        MEM_IDLE  = 2'b00,
        MEM_READ  = 2'b01,
        MEM_WRITE = 2'b11
    } mem_op_t;

    typedef enum logic [2:0] {
        IDLE,
        CMP_RD,
        CMP_WR,
        ACC_RD,
        MEM_WB,
        MEM_RD,
        CACHE_WR
    } ctrl_state_t;

endpackage

/* design/cpu_req_port.sv */
`include "cache_settings.svh"

module cpu_req_port
    import cache_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  logic               rd,
    input  logic               wr,
    input  logic [`ADDR_W-1:0] addr,
    input  logic [`WORD_W-1:0] wdata,
    input  logic               busy,
    output logic               req_valid,
    output cache_addr_t        req_addr,
    output logic [`WORD_W-1:0] req_wdata,
    output logic               req_is_rd,
    output logic               stall
);

    logic accept;

    // Pending request counts as stall until the controller takes it
    assign stall  = req_valid | busy;
    assign accept = (rd | wr) & en & ~stall;

    // Held while en is low so the request is not lost
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
        end else if (accept) begin
            req_valid <= 1'b1;
        end else if (en) begin
            req_valid <= 1'b0;
        end
    end

    // Request payload, kept until the next acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr.word <= addr;  // Raw word, split downstream
            req_wdata     <= wdata;
            req_is_rd     <= rd;    // Read wins if both strobes come
        end
    end

endmodule

/* design/cache_ctrl.sv */
`include "cache_settings.svh"

module cache_ctrl
    import cache_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,
    input  logic                 req_valid,
    input  cache_addr_t          req_addr,
    input  logic [`WORD_W-1:0]   req_wdata,
    input  logic                 req_is_rd,
    input  logic                 hit,
    input  logic                 victim_valid,
    input  logic                 victim_dirty,
    input  logic [`TAG_W-1:0]    victim_tag,
    input  logic [`LINE_W-1:0]   victim_line,
    input  logic [`WORD_W-1:0]   rd_word,
    input  logic                 xfer_done,
    input  logic [`LINE_W-1:0]   fill_line,
    output logic                 busy,
    output logic                 done,
    output logic                 hit_out,
    output logic [`WORD_W-1:0]   rdata,
    output logic [`INDEX_W-1:0]  acc_index,
    output logic [`TAG_W-1:0]    acc_tag,
    output logic [`OFFSET_W-3:0] acc_word,
    output logic                 wr_word,
    output logic [`WORD_W-1:0]   wr_data,
    output logic                 replace,
    output logic                 mark_dirty,
    output logic                 start_wb,
    output logic                 start_fill,
    output cache_addr_t          line_addr,
    output logic [`LINE_W-1:0]   wb_line
);

    ctrl_state_t state, next_state;

    logic        missed;      // Current request missed at least once
    logic        miss_now;
    logic        xfer_seen;   // Transfer finished while frozen
    logic        xfer_ok;
    cache_addr_t wb_addr;
    cache_addr_t fill_addr;

    assign xfer_ok = xfer_done | xfer_seen;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        done       = 1'b0;
        wr_word    = 1'b0;
        replace    = 1'b0;
        start_wb   = 1'b0;
        start_fill = 1'b0;
        miss_now   = 1'b0;
        if (en) begin
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        next_state = req_is_rd ? CMP_RD : CMP_WR;
                    end
                end
                CMP_RD: begin
                    if (hit) begin
                        done       = 1'b1;
                        next_state = IDLE;
                    end else begin
                        miss_now = 1'b1;
                        if (victim_valid & victim_dirty) begin
                            start_wb   = 1'b1;
                            next_state = MEM_WB;
                        end else begin
                            start_fill = 1'b1;
                            next_state = MEM_RD;
                        end
                    end
                end
                CMP_WR: begin
                    if (hit) begin
                        wr_word    = 1'b1;  // Lands at the end of the done cycle
                        done       = 1'b1;
                        next_state = IDLE;
                    end else begin
                        miss_now   = 1'b1;
                        next_state = ACC_RD;
                    end
                end
                ACC_RD: begin
                    if (victim_valid & victim_dirty) begin
                        start_wb   = 1'b1;
                        next_state = MEM_WB;
                    end else begin
                        start_fill = 1'b1;
                        next_state = MEM_RD;
                    end
                end
                MEM_WB: begin
                    if (xfer_ok) begin
                        start_fill = 1'b1;
                        next_state = MEM_RD;
                    end
                end
                MEM_RD: begin
                    if (xfer_ok) begin
                        // A read refills here and compares again
                        replace    = req_is_rd;
                        next_state = req_is_rd ? CMP_RD : CACHE_WR;
                    end
                end
                CACHE_WR: begin
                    replace    = 1'b1;  // Refill and new word in one write
                    wr_word    = 1'b1;
                    done       = 1'b1;
                    next_state = IDLE;
                end
                default: next_state = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            missed    <= 1'b0;
            xfer_seen <= 1'b0;
        end else begin
            if (miss_now) begin
                missed <= 1'b1;
            end else if (done) begin
                missed <= 1'b0;
            end
            if (en) begin
                xfer_seen <= 1'b0;
            end else if (xfer_done) begin
                xfer_seen <= 1'b1;
            end
        end
    end

    // Victim goes back to where it came from
    always_comb begin
        wb_addr          = req_addr;
        wb_addr.f.tag    = victim_tag;
        wb_addr.f.offset = '0;
        fill_addr          = req_addr;
        fill_addr.f.offset = '0;   // Line aligned
    end

    assign line_addr = start_wb ? wb_addr : fill_addr;
    assign wb_line   = victim_line;

    assign acc_index  = req_addr.f.index;
    assign acc_tag    = req_addr.f.tag;
    assign acc_word   = req_addr.f.offset[`OFFSET_W-1:2];
    assign wr_data    = req_wdata;
    assign mark_dirty = wr_word;

    assign busy    = (state != IDLE);
    assign hit_out = done & ~missed;
    assign rdata   = (done & req_is_rd) ? rd_word : '0;

endmodule

/* design/cache_store.sv */
`include "cache_settings.svh"

module cache_store (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`INDEX_W-1:0]  acc_index,
    input  logic [`TAG_W-1:0]    acc_tag,
    input  logic [`OFFSET_W-3:0] acc_word,
    input  logic                 wr_word,
    input  logic [`WORD_W-1:0]   wr_data,
    input  logic                 replace,
    input  logic                 mark_dirty,
    input  logic [`LINE_W-1:0]   fill_line,
    output logic                 hit,
    output logic                 victim_valid,
    output logic                 victim_dirty,
    output logic [`TAG_W-1:0]    victim_tag,
    output logic [`LINE_W-1:0]   victim_line,
    output logic [`WORD_W-1:0]   rd_word
);

    logic [`TAG_W-1:0]     tag_mem  [`NUM_LINES];
    logic [`LINE_W-1:0]    data_mem [`NUM_LINES];
    logic [`NUM_LINES-1:0] valid;
    logic [`NUM_LINES-1:0] dirty;

    logic [`LINE_W-1:0] line_base;
    logic [`LINE_W-1:0] line_next;

    // Current contents of the addressed line
    assign victim_valid = valid[acc_index];
    assign victim_dirty = dirty[acc_index];
    assign victim_tag   = tag_mem[acc_index];
    assign victim_line  = data_mem[acc_index];

    assign hit     = victim_valid & (victim_tag == acc_tag);
    assign rd_word = victim_line[acc_word*`WORD_W +: `WORD_W];

    // Merge the new word over the refill line so the word wins
    always_comb begin
        line_base = replace ? fill_line : victim_line;
        line_next = line_base;
        if (wr_word) begin
            line_next[acc_word*`WORD_W +: `WORD_W] = wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (replace | wr_word) begin
            data_mem[acc_index] <= line_next;
        end
        if (replace) begin
            tag_mem[acc_index] <= acc_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
            dirty <= '0;
        end else if (replace) begin
            valid[acc_index] <= 1'b1;
            dirty[acc_index] <= mark_dirty;  // Clean unless written at once
        end else if (mark_dirty) begin
            dirty[acc_index] <= 1'b1;
        end
    end

endmodule

/* design/mem_line_port.sv */
`include "cache_settings.svh"

module mem_line_port
    import cache_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_wb,
    input  logic               start_fill,
    input  cache_addr_t        line_addr,
    input  logic [`LINE_W-1:0] wb_line,
    input  logic               mem_done,
    input  logic [`LINE_W-1:0] mem_rdata,
    output mem_op_t            mem_op,
    output logic [`ADDR_W-1:0] mem_addr,
    output logic [`LINE_W-1:0] mem_wdata,
    output logic               xfer_done,
    output logic [`LINE_W-1:0] fill_line
);

    logic active;

    assign active = (mem_op != MEM_IDLE);

    // Operation level, held until the memory answers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_op    <= MEM_IDLE;
            xfer_done <= 1'b0;
        end else begin
            xfer_done <= active & mem_done;
            if (active & mem_done) begin
                mem_op <= MEM_IDLE;
            end else if (start_wb) begin
                mem_op <= MEM_WRITE;
            end else if (start_fill) begin
                mem_op <= MEM_READ;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_wb | start_fill) begin
            mem_addr <= line_addr.word;
        end
        if (start_wb) begin
            mem_wdata <= wb_line;    // Victim line for the write-back
        end
        if ((mem_op == MEM_READ) & mem_done) begin
            fill_line <= mem_rdata;  // Refill line for the store
        end
    end

endmodule

/* design/cache_top.sv */
`include "cache_settings.svh"

module cache_top
    import cache_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  logic               rd,
    input  logic               wr,
    input  logic [`ADDR_W-1:0] addr,
    input  logic [`WORD_W-1:0] wdata,
    input  logic               mem_done,
    input  logic [`LINE_W-1:0] mem_rdata,
    output logic               stall,
    output logic               done,
    output logic               hit,
    output logic [`WORD_W-1:0] rdata,
    output mem_op_t            mem_op,
    output logic [`ADDR_W-1:0] mem_addr,
    output logic [`LINE_W-1:0] mem_wdata
);

    // Request side
    logic               busy;
    logic               req_valid;
    cache_addr_t        req_addr;
    logic [`WORD_W-1:0] req_wdata;
    logic               req_is_rd;

    // Store side
    logic                 tag_hit;
    logic                 victim_valid;
    logic                 victim_dirty;
    logic [`TAG_W-1:0]    victim_tag;
    logic [`LINE_W-1:0]   victim_line;
    logic [`WORD_W-1:0]   rd_word;
    logic [`INDEX_W-1:0]  acc_index;
    logic [`TAG_W-1:0]    acc_tag;
    logic [`OFFSET_W-3:0] acc_word;
    logic                 wr_word;
    logic [`WORD_W-1:0]   wr_data;
    logic                 replace;
    logic                 mark_dirty;

    // Memory side
    logic               start_wb;
    logic               start_fill;
    cache_addr_t        line_addr;
    logic [`LINE_W-1:0] wb_line;
    logic               xfer_done;
    logic [`LINE_W-1:0] fill_line;

    cpu_req_port u_req (
        .clk(clk), .rst_n(rst_n), .en(en), .rd(rd), .wr(wr), .addr(addr),
        .wdata(wdata), .busy(busy), .req_valid(req_valid), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_is_rd(req_is_rd), .stall(stall)
    );

    cache_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .en(en), .req_valid(req_valid),
        .req_addr(req_addr), .req_wdata(req_wdata), .req_is_rd(req_is_rd),
        .hit(tag_hit), .victim_valid(victim_valid), .victim_dirty(victim_dirty),
        .victim_tag(victim_tag), .victim_line(victim_line), .rd_word(rd_word),
        .xfer_done(xfer_done), .fill_line(fill_line), .busy(busy), .done(done),
        .hit_out(hit), .rdata(rdata), .acc_index(acc_index), .acc_tag(acc_tag),
        .acc_word(acc_word), .wr_word(wr_word), .wr_data(wr_data),
        .replace(replace), .mark_dirty(mark_dirty), .start_wb(start_wb),
        .start_fill(start_fill), .line_addr(line_addr), .wb_line(wb_line)
    );

    cache_store u_store (
        .clk(clk), .rst_n(rst_n), .acc_index(acc_index), .acc_tag(acc_tag),
        .acc_word(acc_word), .wr_word(wr_word), .wr_data(wr_data),
        .replace(replace), .mark_dirty(mark_dirty), .fill_line(fill_line),
        .hit(tag_hit), .victim_valid(victim_valid), .victim_dirty(victim_dirty),
        .victim_tag(victim_tag), .victim_line(victim_line), .rd_word(rd_word)
    );

    mem_line_port u_mem (
        .clk(clk), .rst_n(rst_n), .start_wb(start_wb), .start_fill(start_fill),
        .line_addr(line_addr), .wb_line(wb_line), .mem_done(mem_done),
        .mem_rdata(mem_rdata), .mem_op(mem_op), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .xfer_done(xfer_done), .fill_line(fill_line)
    );

endmodule

/* bench/tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* bench/host_mem_model.sv */
`include "cache_settings.svh"

module host_mem_model
    import cache_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  mem_op_t            mem_op,
    input  logic [`ADDR_W-1:0] mem_addr,
    input  logic [`LINE_W-1:0] mem_wdata,
    output logic               mem_done,
    output logic [`LINE_W-1:0] mem_rdata
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WORDS = `LINE_W / `WORD_W;

    logic [`LINE_W-1:0] lines [logic [`ADDR_W-1:0]];  // Keyed by line address
    logic [31:0]        lfsr_state = 32'h69cc_c1dd;
    logic               waiting;
    logic [3:0]         wait_left;

    // Three LFSR steps give a delay of 1 to 8 cycles
    function automatic logic [3:0] pick_delay();
        logic [2:0] v;
        int         i;
        v = '0;
        for (i = 0; i < 3; i++) begin
            v = {v[1:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
        end
        return {1'b0, v} + 4'd1;
    endfunction

    function automatic logic [`WORD_W-1:0] fill_word(input logic [`ADDR_W-1:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0ff0;
    endfunction

    // Unwritten lines read back as the address pattern
    function automatic logic [`LINE_W-1:0] read_line(input logic [`ADDR_W-1:0] la);
        logic [`LINE_W-1:0] l;
        int                 w;
        if (lines.exists(la)) begin
            return lines[la];
        end
        for (w = 0; w < WORDS; w++) begin
            l[w*`WORD_W +: `WORD_W] = fill_word(la + (w << 2));
        end
        return l;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_done  <= 1'b0;
            mem_rdata <= '0;
            waiting   <= 1'b0;
            wait_left <= '0;
        end else begin
            mem_done <= 1'b0;
            // mem_op still shows the old level in the cycle of mem_done
            if (!mem_done && mem_op != MEM_IDLE) begin
                if (!waiting) begin
                    waiting   <= 1'b1;
                    wait_left <= pick_delay();
                end else if (wait_left == 4'd1) begin
                    waiting  <= 1'b0;
                    mem_done <= 1'b1;
                    if (mem_op == MEM_WRITE) begin
                        lines[mem_addr] = mem_wdata;
                        $display("memory write line %h", mem_addr);
                    end else begin
                        mem_rdata <= read_line(mem_addr);
                    end
                end else begin
                    wait_left <= wait_left - 4'd1;
                end
            end
        end
    end

endmodule

/* bench/cache_tb.sv */
`include "cache_settings.svh"

module cache_tb
    import cache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TXN    = 400;
    localparam int MAX_CYCLES = NUM_TXN * 40;
    localparam int WORDS      = `LINE_W / `WORD_W;

    logic               clk;
    logic               rst_n;
    logic               en;
    logic               rd;
    logic               wr;
    logic [`ADDR_W-1:0] addr;
    logic [`WORD_W-1:0] wdata;
    logic               mem_done;
    logic [`LINE_W-1:0] mem_rdata;
    logic               stall;
    logic               done;
    logic               hit;
    logic [`WORD_W-1:0] rdata;
    mem_op_t            mem_op;
    logic [`ADDR_W-1:0] mem_addr;
    logic [`LINE_W-1:0] mem_wdata;

    // Reference model
    logic [`WORD_W-1:0] m_words [logic [`ADDR_W-1:0]];  // Coherent word view
    logic [`TAG_W-1:0]  m_tag   [`NUM_LINES];
    logic               m_valid [`NUM_LINES];
    logic               m_dirty [`NUM_LINES];

    logic [31:0] lfsr_state  = 32'h69cc_c1dd;
    int          en_low_left = 0;
    int          cycle_count = 0;
    int          data_errs   = 0;
    int          flag_errs   = 0;
    int          mem_errs    = 0;
    int          time_errs   = 0;
    int          wb_count;
    int          fill_count;
    mem_op_t     prev_op     = MEM_IDLE;

    tb_clock u_clock (.clk(clk), .rst_n(rst_n));

    cache_top dut (
        .clk(clk), .rst_n(rst_n), .en(en), .rd(rd), .wr(wr), .addr(addr),
        .wdata(wdata), .mem_done(mem_done), .mem_rdata(mem_rdata), .stall(stall),
        .done(done), .hit(hit), .rdata(rdata), .mem_op(mem_op),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    host_mem_model u_mem (
        .clk(clk), .rst_n(rst_n), .mem_op(mem_op), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_done(mem_done), .mem_rdata(mem_rdata)
    );

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};  // One step per bit
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic logic [`WORD_W-1:0] fill_word(input logic [`ADDR_W-1:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0ff0;
    endfunction

    // Last written word, else the memory pattern
    function automatic logic [`WORD_W-1:0] model_word(input logic [`ADDR_W-1:0] a);
        if (m_words.exists(a)) begin
            return m_words[a];
        end
        return fill_word(a);
    endfunction

    function automatic logic [`LINE_W-1:0] model_line(input logic [`ADDR_W-1:0] la);
        logic [`LINE_W-1:0] l;
        int                 w;
        for (w = 0; w < WORDS; w++) begin
            l[w*`WORD_W +: `WORD_W] = model_word(la + (w << 2));
        end
        return l;
    endfunction

    // Occasional stretches of en low
    function automatic logic pick_en();
        logic [31:0] r;
        if (en_low_left > 0) begin
            en_low_left--;
            return 1'b0;
        end
        r = take_bits(4);
        if (r[3:0] == 4'd0) begin
            en_low_left = int'(take_bits(2));
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // Checks each new memory transfer against the model
    task automatic watch_mem(input logic [`ADDR_W-1:0] a, input logic exp_wb,
                             input logic last_en);
        logic [`INDEX_W-1:0] idx;
        logic [`ADDR_W-1:0]  wb_addr;
        logic [`ADDR_W-1:0]  fill_addr;
        idx       = a[`OFFSET_W +: `INDEX_W];
        wb_addr   = {m_tag[idx], idx, {`OFFSET_W{1'b0}}};
        fill_addr = {a[`ADDR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};
        if (mem_op != prev_op && mem_op != MEM_IDLE) begin
            if (!last_en) begin
                $display("memory transfer started after a cycle with en low");
                flag_errs++;
            end
            if (mem_op == MEM_WRITE) begin
                wb_count++;
                if (!exp_wb) begin
                    $display("write-back of a line the model holds clean or invalid");
                    mem_errs++;
                end
                if (mem_addr !== wb_addr) begin
                    $display("CHECK FAILED mem_addr: expected %h, got %h", wb_addr, mem_addr);
                    mem_errs++;
                end
                if (mem_wdata !== model_line(wb_addr)) begin
                    $display("CHECK FAILED mem_wdata: expected %h, got %h",
                             model_line(wb_addr), mem_wdata);
                    mem_errs++;
                end
            end else begin
                fill_count++;
                if (mem_addr !== fill_addr) begin
                    $display("CHECK FAILED mem_addr: expected %h, got %h", fill_addr, mem_addr);
                    mem_errs++;
                end
            end
        end
        prev_op = mem_op;
    endtask

    task automatic run_txn();
        logic [31:0]         r;
        logic                is_rd;
        logic [`ADDR_W-1:0]  a;
        logic [`WORD_W-1:0]  d;
        logic [`INDEX_W-1:0] idx;
        logic [`TAG_W-1:0]   tg;
        logic                exp_hit;
        logic                exp_wb;
        logic                last_en;
        logic                stall_seen;
        int                  active;
        r     = take_bits(9);
        is_rd = r[0];
        tg    = {r[2:1], 16'h35c1};  // Four tags over four indices
        idx   = {6'h2d, r[4:3]};
        a     = {tg, idx, r[8:5], 2'b00};
        d     = take_bits(32);
        exp_hit    = m_valid[idx] && (m_tag[idx] == tg);
        exp_wb     = !exp_hit && m_valid[idx] && m_dirty[idx];
        active     = 0;
        wb_count   = 0;
        fill_count = 0;
        last_en    = 1'b1;

        @(posedge clk);
        rd    <= is_rd;
        wr    <= !is_rd;
        addr  <= a;
        wdata <= d;
        en    <= 1'b1;
        @(posedge clk);  // Accepted at this edge
        rd <= 1'b0;
        wr <= 1'b0;
        en <= pick_en();
        @(negedge clk);
        while (!done) begin
            if (en) begin
                active++;
            end
            watch_mem(a, exp_wb, last_en);
            last_en    = en;
            stall_seen = stall;
            if (!stall) begin
                $display("stall low while a request is still in flight");
                flag_errs++;
            end
            @(posedge clk);
            en <= pick_en();
            r = take_bits(3);
            // Stray strobes while stalled must be ignored
            if (r[1:0] == 2'b00 && stall_seen) begin
                rd    <= r[2];
                wr    <= !r[2];
                addr  <= take_bits(32);
                wdata <= take_bits(32);
            end else begin
                rd <= 1'b0;
                wr <= 1'b0;
            end
            @(negedge clk);
        end

        watch_mem(a, exp_wb, last_en);
        if (en) begin
            active++;
        end else begin
            $display("done raised while en was low");
            flag_errs++;
        end
        if (!stall) begin
            $display("stall low in the done cycle");
            flag_errs++;
        end
        if (hit !== exp_hit) begin
            $display("CHECK FAILED hit at %h: expected %h, got %h", a, exp_hit, hit);
            flag_errs++;
        end
        if (exp_hit && active != 2) begin
            $display("hit at %h took %0d active cycles instead of 2", a, active);
            time_errs++;
        end
        if (is_rd && rdata !== model_word(a)) begin
            $display("CHECK FAILED rdata at %h: expected %h, got %h", a, model_word(a), rdata);
            data_errs++;
        end
        if (wb_count != (exp_wb ? 1 : 0) || fill_count != (exp_hit ? 0 : 1)) begin
            $display("access at %h made %0d write-backs and %0d refills, model disagrees",
                     a, wb_count, fill_count);
            mem_errs++;
        end

        if (!exp_hit) begin
            m_tag[idx]   = tg;
            m_valid[idx] = 1'b1;
            m_dirty[idx] = 1'b0;
        end
        if (!is_rd) begin
            m_words[a]   = d;
            m_dirty[idx] = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the cache stopped answering", cycle_count);
            $display("errors: data %0d, flags %0d, memory %0d, timing %0d",
                     data_errs, flag_errs, mem_errs, time_errs);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        int i;
        en    = 1'b0;
        rd    = 1'b0;
        wr    = 1'b0;
        addr  = '0;
        wdata = '0;
        for (i = 0; i < `NUM_LINES; i++) begin
            m_tag[i]   = '0;
            m_valid[i] = 1'b0;
            m_dirty[i] = 1'b0;
        end

        @(posedge rst_n);
        @(negedge clk);
        if (stall !== 1'b0) begin
            $display("CHECK FAILED stall after reset: expected 0, got %h", stall);
            flag_errs++;
        end
        if (done !== 1'b0) begin
            $display("CHECK FAILED done after reset: expected 0, got %h", done);
            flag_errs++;
        end
        if (hit !== 1'b0) begin
            $display("CHECK FAILED hit after reset: expected 0, got %h", hit);
            flag_errs++;
        end
        if (mem_op !== MEM_IDLE) begin
            $display("CHECK FAILED mem_op after reset: expected %h, got %h", MEM_IDLE, mem_op);
            mem_errs++;
        end

        repeat (NUM_TXN) run_txn();

        @(posedge clk);
        rd <= 1'b0;
        wr <= 1'b0;
        en <= 1'b1;
        @(negedge clk);
        $display("errors: data %0d, flags %0d, memory %0d, timing %0d",
                 data_errs, flag_errs, mem_errs, time_errs);
        if (data_errs + flag_errs + mem_errs + time_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+design
design/cache_pkg.sv
design/cpu_req_port.sv
design/cache_ctrl.sv
design/cache_store.sv
design/mem_line_port.sv
design/cache_top.sv
bench/tb_clock.sv
bench/host_mem_model.sv
bench/cache_tb.sv

/* Bender.yml */
package:
  name: dcache

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/cache_pkg.sv
      - design/cpu_req_port.sv
      - design/cache_ctrl.sv
      - design/cache_store.sv
      - design/mem_line_port.sv
      - design/cache_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/tb_clock.sv
      - bench/host_mem_model.sv
      - bench/cache_tb.sv
